// File: rtl/aluPipePkg.sv
package aluPipePkg;

    // operation select shared by decode and the ALU stage
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSll16,
        aluBad
    } aluOpE;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeS;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeS;

    // one instruction word, viewed by format
    typedef union packed {
        rTypeS r;
        iTypeS i;
    } instrU;

    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opSlti = 6'h0A;
    localparam logic [5:0] opAndi = 6'h0C;
    localparam logic [5:0] opOri  = 6'h0D;
    localparam logic [5:0] opXori = 6'h0E;
    localparam logic [5:0] opLui  = 6'h0F;

    // funct field, R-type only
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2A;

endpackage

// File: rtl/regFile.sv
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // r0 is hardwired
    assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

// File: rtl/instrDecode.sv
module instrDecode (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  aluPipePkg::instrU instr,
    output logic [4:0]        rdAddrA,
    output logic [4:0]        rdAddrB,
    input  logic [31:0]       rdDataA,
    input  logic [31:0]       rdDataB,
    input  logic              exValid,
    input  logic [4:0]        exDest,
    input  logic [31:0]       exResult,
    input  logic              wbValid,
    input  logic [4:0]        wbDest,
    input  logic [31:0]       wbResult,
    output logic              decValid,
    output aluPipePkg::aluOpE decOp,
    output logic [31:0]       decLeft,
    output logic [31:0]       decRight,
    output logic [4:0]        decDest
);
    import aluPipePkg::*;

    aluOpE       op;
    logic        isRType;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    logic [31:0] immSext;
    logic [31:0] immZext;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] right;

    assign isRType = (instr.r.opcode == opR);
    assign rs      = instr.i.rs;
    assign rt      = instr.i.rt;
    assign dest    = isRType ? instr.r.rd : instr.i.rt;
    assign immSext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign immZext = {16'h0000, instr.i.imm};

    assign rdAddrA = rs;
    assign rdAddrB = rt;

    // stage 2 result is newer than writeback, so it wins
    assign srcA = (rs != 5'd0 && exValid && exDest == rs) ? exResult :
                  (rs != 5'd0 && wbValid && wbDest == rs) ? wbResult : rdDataA;
    assign srcB = (rt != 5'd0 && exValid && exDest == rt) ? exResult :
                  (rt != 5'd0 && wbValid && wbDest == rt) ? wbResult : rdDataB;

    always_comb begin
        op    = aluBad;
        right = immZext;
        if (isRType) begin
            right = srcB;
            case (instr.r.funct)
                fnAdd:   op = aluAdd;
                fnSub:   op = aluSub;
                fnAnd:   op = aluAnd;
                fnOr:    op = aluOr;
                fnXor:   op = aluXor;
                fnNor:   op = aluNor;
                fnSlt:   op = aluSlt;
                fnSllv:  op = aluSll;
                fnSrlv:  op = aluSrl;
                default: op = aluBad;
            endcase
        end else begin
            case (instr.i.opcode)
                opAddi: begin
                    op    = aluAdd;
                    right = immSext;
                end
                opSlti: begin
                    op    = aluSlt;
                    right = immSext;
                end
                opAndi:  op = aluAnd;
                opOri:   op = aluOr;
                opXori:  op = aluXor;
                opLui:   op = aluSll16;
                default: op = aluBad;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
            decOp    <= aluAdd;
            decLeft  <= 32'd0;
            decRight <= 32'd0;
            decDest  <= 5'd0;
        end else begin
            decValid <= instrValid;
            decOp    <= op;
            decLeft  <= srcA;
            decRight <= right;
            decDest  <= dest;
        end
    end

endmodule

// File: rtl/alu32b.sv
module alu32b (
    input  logic              clk,
    input  logic              rstN,
    input  logic              decValid,
    input  aluPipePkg::aluOpE decOp,
    input  logic [31:0]       decLeft,
    input  logic [31:0]       decRight,
    input  logic [4:0]        decDest,
    output logic [31:0]       exResult,
    output logic              resultValid,
    output logic [31:0]       result,
    output logic [4:0]        resultDest,
    output logic              zero
);
    import aluPipePkg::*;

    logic [31:0] sum;
    logic [31:0] diff;

    assign sum  = decLeft + decRight;
    assign diff = decLeft - decRight;

    // shift amount comes from the left operand, rt is shifted
    always_comb begin
        case (decOp)
            aluAdd:   exResult = sum;
            aluSub:   exResult = diff;
            aluAnd:   exResult = decLeft & decRight;
            aluOr:    exResult = decLeft | decRight;
            aluXor:   exResult = decLeft ^ decRight;
            aluNor:   exResult = ~(decLeft | decRight);
            aluSlt:   exResult = {31'd0, diff[31]};
            aluSll:   exResult = decRight << decLeft[4:0];
            aluSrl:   exResult = decRight >> decLeft[4:0];
            aluSll16: exResult = decRight << 16;
            default:  exResult = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            result      <= 32'd0;
            resultDest  <= 5'd0;
        end else begin
            resultValid <= decValid;
            result      <= exResult;
            resultDest  <= decDest;
        end
    end

    assign zero = (result == 32'd0);

endmodule

// File: rtl/aluPipeTop.sv
module aluPipeTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  aluPipePkg::instrU instr,
    output logic              resultValid,
    output logic [31:0]       result,
    output logic [4:0]        resultDest,
    output logic              zero
);
    import aluPipePkg::*;

    logic        decValid;
    aluOpE       decOp;
    logic [31:0] decLeft;
    logic [31:0] decRight;
    logic [4:0]  decDest;
    logic [31:0] exResult;
    logic [4:0]  rdAddrA;
    logic [4:0]  rdAddrB;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;

    instrDecode decode (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .exValid    (decValid),
        .exDest     (decDest),
        .exResult   (exResult),
        .wbValid    (resultValid),
        .wbDest     (resultDest),
        .wbResult   (result),
        .decValid   (decValid),
        .decOp      (decOp),
        .decLeft    (decLeft),
        .decRight   (decRight),
        .decDest    (decDest)
    );

    alu32b alu (
        .clk         (clk),
        .rstN        (rstN),
        .decValid    (decValid),
        .decOp       (decOp),
        .decLeft     (decLeft),
        .decRight    (decRight),
        .decDest     (decDest),
        .exResult    (exResult),
        .resultValid (resultValid),
        .result      (result),
        .resultDest  (resultDest),
        .zero        (zero)
    );

    // writeback straight from the ALU output register
    regFile regs (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (resultValid),
        .wrAddr  (resultDest),
        .wrData  (result)
    );

endmodule

// File: testbench/aluPipe_assert.sv
module aluPipeAssert (
    input logic        clk,
    input logic        rstN,
    input logic        instrValid,
    input logic        resultValid,
    input logic [31:0] result,
    input logic        zero
);
    timeunit 1ns;
    timeprecision 100ps;

    resetQuiet: assert property (@(posedge clk) !rstN |-> !resultValid)
        else $error("resultValid high while reset is asserted");

    zeroFlag: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> (zero == (result == 32'd0)))
        else $error("zero flag disagrees with result");

    // decode register, then ALU output register
    fixedLatency: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> ##2 resultValid)
        else $error("resultValid missing two cycles after instrValid");

endmodule

bind aluPipeTop aluPipeAssert assertChecks (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .resultValid (resultValid),
    .result      (result),
    .zero        (zero)
);

// File: testbench/aluPipeTb.sv
module aluPipeTb;
    timeunit 1ns;
    timeprecision 100ps;
    import aluPipePkg::*;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    instrU       instr;
    logic        resultValid;
    logic [31:0] result;
    logic [4:0]  resultDest;
    logic        zero;

    // register state in program order, plus results still in flight
    logic [31:0] refRegs [32];
    logic [31:0] expWords [$];
    logic [4:0]  expDests [$];
    logic [5:0]  fnList [7];
    logic [15:0] lfsr;

    aluPipeTop UUT (.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .resultValid(resultValid), .result(result), .resultDest(resultDest), .zero(zero));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            reportFailure($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic checkDest(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            reportFailure($sformatf("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("MISMATCH %s got 0x%1h expected 0x%1h", name, got, exp));
        end
    endtask

    function automatic instrU rInstr(input logic [5:0] fn, input logic [4:0] rs, rt, rd);
        instrU w;
        w.r = '{opR, rs, rt, rd, 5'd0, fn};
        return w;
    endfunction

    function automatic instrU iInstr(input logic [5:0] op, input logic [4:0] rs, rt,
                                     input logic [15:0] imm);
        instrU w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    // expected value from the instruction rules, on the in-order state
    function automatic logic [31:0] expectedValue(input instrU w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] v;
        a    = refRegs[w.r.rs];
        b    = (w.r.opcode == opR) ? refRegs[w.r.rt] : {16'h0000, w.i.imm};
        sext = {{16{w.i.imm[15]}}, w.i.imm};
        case (w.i.opcode)
            opR: begin
                case (w.r.funct)
                    fnAdd:   v = a + b;
                    fnSub:   v = a - b;
                    fnAnd:   v = a & b;
                    fnOr:    v = a | b;
                    fnXor:   v = a ^ b;
                    fnNor:   v = ~(a | b);
                    fnSlt:   v = (a - b) >> 31;
                    fnSllv:  v = b << a[4:0];
                    fnSrlv:  v = b >> a[4:0];
                    default: v = 32'd0;
                endcase
            end
            opAddi:  v = a + sext;
            opSlti:  v = (a - sext) >> 31;
            opAndi:  v = a & b;
            opOri:   v = a | b;
            opXori:  v = a ^ b;
            opLui:   v = {w.i.imm, 16'h0000};
            default: v = 32'd0;
        endcase
        return v;
    endfunction

    // one instruction for one cycle, expected result queued
    task automatic issue(input instrU w);
        logic [31:0] v;
        logic [4:0]  d;
        v = expectedValue(w);
        d = (w.r.opcode == opR) ? w.r.rd : w.i.rt;
        @(negedge clk);
        instrValid = 1'b1;
        instr      = w;
        expWords.push_back(v);
        expDests.push_back(d);
        if (d != 5'd0) begin
            refRegs[d] = v;
        end
    endtask

    task automatic drain();
        int waited;
        @(negedge clk);
        instrValid = 1'b0;
        waited     = 0;
        while (expWords.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                reportFailure("timeout: resultValid never came for an issued instruction");
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstN && resultValid) begin
            if (expWords.size() == 0) begin
                reportFailure("resultValid went high with no instruction outstanding");
            end else begin
                checkWord("result", result, expWords[0]);
                checkDest("resultDest", resultDest, expDests[0]);
                checkFlag("zero", zero, expWords[0] == 32'd0);
                void'(expWords.pop_front());
                void'(expDests.pop_front());
            end
        end
    end

    task automatic resetState();
        checkFlag("resultValid", resultValid, 1'b0);
        issue(rInstr(fnAdd, 5'd0, 5'd0, 5'd1));
        drain();
    endtask

    task automatic immediateForms();
        logic [31:0] c;
        for (int k = 1; k <= 4; k++) begin
            c = randBits(32);
            issue(iInstr(opLui, 5'd0, 5'(k), c[31:16]));
            issue(iInstr(opOri, 5'(k), 5'(k), c[15:0]));
        end
        // bit 15 set in every immediate
        issue(iInstr(opAddi, 5'd1, 5'd5, 16'h8000 | 16'(randBits(15))));
        issue(iInstr(opSlti, 5'd2, 5'd6, 16'h8000 | 16'(randBits(15))));
        issue(iInstr(opAndi, 5'd3, 5'd7, 16'h8000 | 16'(randBits(15))));
        issue(iInstr(opXori, 5'd4, 5'd8, 16'h8000 | 16'(randBits(15))));
        drain();
    endtask

    task automatic registerAlu();
        for (int k = 0; k < 14; k++) begin
            issue(rInstr(fnList[3'(k % 7)], 5'(randBits(3) + 1), 5'(randBits(3) + 1),
                         5'(randBits(3) + 9)));
        end
        // difference overflows, slt follows its sign bit
        issue(iInstr(opLui, 5'd0, 5'd20, 16'h7FFF));
        issue(iInstr(opOri, 5'd20, 5'd20, 16'hFFFF));
        issue(iInstr(opLui, 5'd0, 5'd21, 16'h8000));
        issue(rInstr(fnSlt, 5'd20, 5'd21, 5'd22));
        issue(rInstr(fnSlt, 5'd21, 5'd20, 5'd22));
        drain();
    endtask

    task automatic variableShifts();
        logic [4:0] amt;
        for (int k = 0; k < 8; k++) begin
            amt = (k < 2) ? 5'd0 : (k < 4) ? 5'd31 : 5'(randBits(5));
            issue(iInstr(opOri, 5'd0, 5'd12, {11'(randBits(11)), amt}));
            issue(rInstr(k[0] ? fnSrlv : fnSllv, 5'd12, 5'(randBits(2) + 1), 5'd13));
        end
        drain();
    endtask

    // rt from the previous instruction, rs from the one before
    task automatic dependentChain();
        for (int k = 0; k < 12; k++) begin
            issue(rInstr(fnList[3'(k % 7)], 5'(k % 4 + 1), 5'((k + 1) % 4 + 1),
                         5'((k + 2) % 4 + 1)));
        end
        // third addi sees r1 in both stage 2 and writeback
        issue(iInstr(opAddi, 5'd1, 5'd1, 16'hFFFD));
        issue(iInstr(opAddi, 5'd1, 5'd1, 16'h0011));
        issue(iInstr(opAddi, 5'd1, 5'd1, 16'h0100));
        drain();
    endtask

    task automatic illegalAndR0();
        issue(iInstr(6'h23, 5'd1, 5'd14, 16'(randBits(16))));
        issue(rInstr(6'h3F, 5'd1, 5'd2, 5'd15));
        // r0 write right before an r0 read
        issue(iInstr(opAddi, 5'd1, 5'd0, 16'h0005));
        issue(rInstr(fnOr, 5'd0, 5'd0, 5'd16));
        drain();
    endtask

    initial begin
        lfsr       = 16'd39852;
        rstN       = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        fnList     = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt};
        foreach (refRegs[i]) begin
            refRegs[i] = 32'd0;
        end
        // real falling edge on the async reset
        #10 rstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        resetState();
        immediateForms();
        registerAlu();
        variableShifts();
        dependentChain();
        illegalAndR0();
        $display("No errors");
        $finish;
    end

endmodule

// File: aluPipe.f
rtl/aluPipePkg.sv
rtl/regFile.sv
rtl/instrDecode.sv
rtl/alu32b.sv
rtl/aluPipeTop.sv
testbench/aluPipe_assert.sv
testbench/aluPipeTb.sv

// File: Makefile
# Verilator simulation of the ALU pipeline
TOP = aluPipeTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f aluPipe.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
